// File: design/icachePkg.sv
package icachePkg;

    // address split is tag [31:10], set [9:4], byte in line [3:0]
    typedef logic [31:0]  addrT;
    typedef logic [31:0]  instT;
    typedef logic [127:0] lineT;
    typedef logic [21:0]  tagT;
    typedef logic [5:0]   setIdxT;
    typedef logic [1:0]   wayIdxT;

    // tree bits: bit2 picks the half, bit0 and bit1 the way inside it
    typedef logic [2:0]   ageT;

    typedef struct packed {
        addrT pc;
        logic inst0Valid;
        logic inst1Valid;
        instT inst0;
        instT inst1;
    } fetchBundleT;

    typedef struct packed {
        addrT lineAddr;
    } memReqT;

    typedef struct packed {
        logic   en;
        setIdxT set;
        wayIdxT way;
        tagT    tag;
        lineT   line;
    } storeWriteT;

    typedef enum logic [1:0] {
        idle,
        request,
        waitResp,
        fill
    } refillStateT;

endpackage

// File: design/fetchLookup.sv
`timescale 1ns/1ps

module fetchLookup #(
    parameter int numSets = 64,
    parameter int numWays = 4
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              fetchValid,
    input  icachePkg::addrT                   fetchPc,
    input  icachePkg::tagT  [numWays-1:0]     wayTags,
    input  icachePkg::lineT [numWays-1:0]     wayLines,
    input  logic            [numWays-1:0]     wayValid,
    input  logic                              refillDone,
    input  icachePkg::lineT                   refillLine,
    output logic                              fetchReady,
    output icachePkg::setIdxT                 readSet,
    output logic                              hitValid,
    output icachePkg::setIdxT                 hitSet,
    output icachePkg::wayIdxT                 hitWay,
    output logic                              missValid,
    output icachePkg::addrT                   missAddr,
    output logic                              bundleValid,
    output icachePkg::fetchBundleT            bundle
);
    localparam int setBits = $clog2(numSets);
    localparam int tagBits = $bits(icachePkg::tagT);

    logic               started;
    logic               s1Valid;
    logic               missPending;
    logic               accept;
    logic               anyMatch;
    logic [numWays-1:0] match;
    icachePkg::addrT    s1Pc;
    icachePkg::tagT     s1Tag;
    icachePkg::lineT    srcLine;

    // ready comes back as soon as the compare stage empties or delivers
    assign fetchReady = started && (!s1Valid || hitValid || refillDone);
    assign accept     = fetchValid && fetchReady;
    assign readSet    = icachePkg::setIdxT'(fetchPc[4 +: setBits]);

    always_comb begin
        match  = '0;
        hitWay = '0;
        for (int w = numWays - 1; w >= 0; w--) begin
            match[w] = wayValid[w] && (wayTags[w] == s1Tag);
            if (match[w]) begin
                hitWay = icachePkg::wayIdxT'(w);
            end
        end
    end

    assign anyMatch    = |match;
    // array outputs are stale once a miss is outstanding
    assign hitValid    = s1Valid && !missPending && anyMatch;
    assign missValid   = s1Valid && (missPending || !anyMatch);
    assign missAddr    = s1Pc;
    assign hitSet      = icachePkg::setIdxT'(s1Pc[4 +: setBits]);
    assign bundleValid = hitValid || refillDone;
    assign srcLine     = refillDone ? refillLine : wayLines[hitWay];

    always_comb begin
        bundle.pc         = {s1Pc[31:3], 3'b000};
        bundle.inst0Valid = !s1Pc[2];
        bundle.inst1Valid = 1'b1;
        bundle.inst0      = srcLine[{s1Pc[3], 6'd0} +: 32];
        bundle.inst1      = srcLine[{s1Pc[3], 6'd32} +: 32];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            started     <= 1'b0;
            s1Valid     <= 1'b0;
            missPending <= 1'b0;
        end else begin
            started <= 1'b1;
            if (accept) begin
                s1Valid <= 1'b1;
            end else if (bundleValid) begin
                s1Valid <= 1'b0;
            end
            if (refillDone) begin
                missPending <= 1'b0;
            end else if (missValid) begin
                missPending <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            s1Pc  <= fetchPc;
            s1Tag <= fetchPc[31 -: tagBits];
        end
    end

endmodule

// File: design/cacheStore.sv
`timescale 1ns/1ps

module cacheStore #(
    parameter int numSets = 64,
    parameter int numWays = 4
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              flush,
    input  icachePkg::setIdxT                 readSet,
    input  logic                              hitValid,
    input  icachePkg::setIdxT                 hitSet,
    input  icachePkg::wayIdxT                 hitWay,
    input  icachePkg::storeWriteT             storeWrite,
    input  icachePkg::setIdxT                 victimSet,
    output icachePkg::tagT  [numWays-1:0]     wayTags,
    output icachePkg::lineT [numWays-1:0]     wayLines,
    output logic            [numWays-1:0]     wayValid,
    output icachePkg::wayIdxT                 victimWay
);
    icachePkg::tagT     tagMem    [numWays][numSets];
    icachePkg::lineT    dataMem   [numWays][numSets];
    logic [numWays-1:0] validBits [numSets];
    icachePkg::ageT     ageBits   [numSets];

    // point the tree away from the way just used
    function automatic icachePkg::ageT touch(icachePkg::ageT age, icachePkg::wayIdxT way);
        icachePkg::ageT next;
        next    = age;
        next[2] = !way[1];
        if (way[1]) begin
            next[1] = !way[0];
        end else begin
            next[0] = !way[0];
        end
        return next;
    endfunction

    // write-first, so a fetch to a line filled this cycle sees the new line
    always_ff @(posedge clk) begin
        for (int w = 0; w < numWays; w++) begin
            if (storeWrite.en && storeWrite.way == icachePkg::wayIdxT'(w)) begin
                tagMem[w][storeWrite.set]  <= storeWrite.tag;
                dataMem[w][storeWrite.set] <= storeWrite.line;
            end
            if (storeWrite.en && storeWrite.way == icachePkg::wayIdxT'(w)
                    && storeWrite.set == readSet) begin
                wayTags[w]  <= storeWrite.tag;
                wayLines[w] <= storeWrite.line;
            end else begin
                wayTags[w]  <= tagMem[w][readSet];
                wayLines[w] <= dataMem[w][readSet];
            end
        end
    end

    // flush beats a fill landing in the same cycle
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            wayValid <= '0;
            for (int s = 0; s < numSets; s++) begin
                validBits[s] <= '0;
                ageBits[s]   <= '0;
            end
        end else begin
            wayValid <= validBits[readSet];
            if (storeWrite.en && storeWrite.set == readSet) begin
                wayValid[storeWrite.way] <= 1'b1;
            end
            if (hitValid) begin
                ageBits[hitSet] <= touch(ageBits[hitSet], hitWay);
            end
            if (storeWrite.en) begin
                validBits[storeWrite.set][storeWrite.way] <= 1'b1;
                ageBits[storeWrite.set] <= touch(ageBits[storeWrite.set], storeWrite.way);
            end
        end
    end

    always_comb begin : victimPick
        icachePkg::ageT age;
        logic           found;
        age   = ageBits[victimSet];
        found = 1'b0;
        victimWay = age[2] ? {1'b1, age[1]} : {1'b0, age[0]};
        // an empty way is always taken first
        for (int w = 0; w < numWays; w++) begin
            if (!found && !validBits[victimSet][w]) begin
                victimWay = icachePkg::wayIdxT'(w);
                found     = 1'b1;
            end
        end
    end

endmodule

// File: design/refillEngine.sv
`timescale 1ns/1ps

module refillEngine (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   missValid,
    input  icachePkg::addrT        missAddr,
    input  icachePkg::wayIdxT      victimWay,
    input  logic                   memReqReady,
    input  logic                   memRespValid,
    input  icachePkg::lineT        memRespLine,
    output icachePkg::setIdxT      victimSet,
    output logic                   memReqValid,
    output icachePkg::memReqT      memReq,
    output logic                   memRespReady,
    output icachePkg::storeWriteT  storeWrite,
    output logic                   refillDone,
    output icachePkg::lineT        refillLine
);
    localparam int setBits = $bits(icachePkg::setIdxT);
    localparam int tagBits = $bits(icachePkg::tagT);

    icachePkg::refillStateT state;
    icachePkg::refillStateT nextState;
    icachePkg::addrT        lineAddr;
    icachePkg::lineT        lineBuf;

    always_comb begin
        nextState = state;
        case (state)
            icachePkg::idle: begin
                if (missValid) begin
                    nextState = icachePkg::request;
                end
            end
            icachePkg::request: begin
                if (memReqReady) begin
                    nextState = icachePkg::waitResp;
                end
            end
            icachePkg::waitResp: begin
                if (memRespValid) begin
                    nextState = icachePkg::fill;
                end
            end
            default: begin
                nextState = icachePkg::idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= icachePkg::idle;
        end else begin
            state <= nextState;
        end
    end

    // miss address and returned line are held for the whole refill
    always_ff @(posedge clk) begin
        if (state == icachePkg::idle && missValid) begin
            lineAddr <= {missAddr[31:4], 4'b0000};
        end
        if (state == icachePkg::waitResp && memRespValid) begin
            lineBuf <= memRespLine;
        end
    end

    assign memReqValid     = (state == icachePkg::request);
    assign memReq.lineAddr = lineAddr;
    assign memRespReady    = (state == icachePkg::waitResp);
    assign victimSet       = lineAddr[4 +: setBits];

    assign refillDone = (state == icachePkg::fill);
    assign refillLine = lineBuf;

    always_comb begin
        storeWrite.en   = refillDone;
        storeWrite.set  = victimSet;
        storeWrite.way  = victimWay;
        storeWrite.tag  = lineAddr[31 -: tagBits];
        storeWrite.line = lineBuf;
    end

endmodule

// File: design/icacheTop.sv
`timescale 1ns/1ps

module icacheTop #(
    parameter int numSets = 64,
    parameter int numWays = 4
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    flush,
    input  logic                    fetchValid,
    output logic                    fetchReady,
    input  icachePkg::addrT         fetchPc,
    output logic                    bundleValid,
    output icachePkg::fetchBundleT  bundle,
    output logic                    memReqValid,
    input  logic                    memReqReady,
    output icachePkg::memReqT       memReq,
    input  logic                    memRespValid,
    output logic                    memRespReady,
    input  icachePkg::lineT         memRespLine
);
    icachePkg::setIdxT                readSet;
    icachePkg::tagT  [numWays-1:0]    wayTags;
    icachePkg::lineT [numWays-1:0]    wayLines;
    logic            [numWays-1:0]    wayValid;
    logic                             hitValid;
    icachePkg::setIdxT                hitSet;
    icachePkg::wayIdxT                hitWay;
    logic                             missValid;
    icachePkg::addrT                  missAddr;
    logic                             refillDone;
    icachePkg::lineT                  refillLine;
    icachePkg::storeWriteT            storeWrite;
    icachePkg::setIdxT                victimSet;
    icachePkg::wayIdxT                victimWay;

    fetchLookup #(
        .numSets(numSets),
        .numWays(numWays)
    ) fetchLookup_i (
        .clk(clk), .rst(rst), .fetchValid(fetchValid), .fetchPc(fetchPc),
        .wayTags(wayTags), .wayLines(wayLines), .wayValid(wayValid),
        .refillDone(refillDone), .refillLine(refillLine), .fetchReady(fetchReady),
        .readSet(readSet), .hitValid(hitValid), .hitSet(hitSet), .hitWay(hitWay),
        .missValid(missValid), .missAddr(missAddr),
        .bundleValid(bundleValid), .bundle(bundle)
    );

    cacheStore #(
        .numSets(numSets),
        .numWays(numWays)
    ) cacheStore_i (
        .clk(clk), .rst(rst), .flush(flush), .readSet(readSet),
        .hitValid(hitValid), .hitSet(hitSet), .hitWay(hitWay),
        .storeWrite(storeWrite), .victimSet(victimSet),
        .wayTags(wayTags), .wayLines(wayLines), .wayValid(wayValid),
        .victimWay(victimWay)
    );

    refillEngine refillEngine_i (
        .clk(clk), .rst(rst), .missValid(missValid), .missAddr(missAddr),
        .victimWay(victimWay), .memReqReady(memReqReady),
        .memRespValid(memRespValid), .memRespLine(memRespLine),
        .victimSet(victimSet), .memReqValid(memReqValid), .memReq(memReq),
        .memRespReady(memRespReady), .storeWrite(storeWrite),
        .refillDone(refillDone), .refillLine(refillLine)
    );

endmodule

// File: sim/tbClock.sv
`timescale 1ns/1ps

module tbClock #(
    parameter int halfPeriod  = 2,
    parameter int resetCycles = 10
) (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #(halfPeriod) clk = ~clk;
    end

    // release lands just after an edge like every other input
    initial begin
        rst = 1'b1;
        repeat (resetCycles) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

// File: sim/icacheMonitor.sv
`timescale 1ns/1ps

module icacheMonitor #(
    parameter int          numSets = 64,
    parameter int          numWays = 4,
    parameter logic [31:0] memKey  = 32'h0
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    flush,
    input  logic                    fetchValid,
    input  logic                    fetchReady,
    input  icachePkg::addrT         fetchPc,
    input  logic                    bundleValid,
    input  icachePkg::fetchBundleT  bundle,
    input  logic                    memReqValid,
    input  logic                    memReqReady,
    input  icachePkg::memReqT       memReq,
    input  logic                    memRespValid,
    input  logic                    memRespReady,
    output int                      errorCount,
    output int                      acceptCount,
    output int                      bundleCount,
    output int                      reqCount
);
    icachePkg::tagT  modelTag   [numSets][numWays];
    logic            modelValid [numSets][numWays];
    logic [2:0]      modelAge   [numSets];

    // the fetch sitting in the compare stage
    logic            pendValid;
    logic            pendHit;
    logic            pendReqSeen;
    logic            pendRespSeen;
    logic [1:0]      pendWay;
    icachePkg::addrT pendPc;

    function automatic logic [2:0] ageAfterUse(logic [2:0] age, logic [1:0] way);
        logic [2:0] next;
        next = age;
        case (way)
            2'd0: begin
                next[2] = 1'b1;
                next[0] = 1'b1;
            end
            2'd1: begin
                next[2] = 1'b1;
                next[0] = 1'b0;
            end
            2'd2: begin
                next[2] = 1'b0;
                next[1] = 1'b1;
            end
            default: begin
                next[2] = 1'b0;
                next[1] = 1'b0;
            end
        endcase
        return next;
    endfunction

    function automatic logic [1:0] pickVictim(int set);
        for (int w = 0; w < numWays; w++) begin
            if (!modelValid[set][w]) begin
                return 2'(w);
            end
        end
        if (modelAge[set][2]) begin
            return {1'b1, modelAge[set][1]};
        end
        return {1'b0, modelAge[set][0]};
    endfunction

    task automatic reportError(string msg);
        errorCount++;
        $display("[ERROR] %0t: %s", $time, msg);
    endtask

    task automatic clearModel();
        for (int s = 0; s < numSets; s++) begin
            modelAge[s] = 3'b000;
            for (int w = 0; w < numWays; w++) begin
                modelValid[s][w] = 1'b0;
            end
        end
    endtask

    task automatic checkBundle(icachePkg::addrT pc);
        icachePkg::addrT base;
        base = {pc[31:3], 3'b000};
        if (bundle.pc !== base) begin
            reportError($sformatf("pc %h, expected %h", bundle.pc, base));
        end
        if (bundle.inst0Valid !== !pc[2] || bundle.inst1Valid !== 1'b1) begin
            reportError($sformatf("valid flags %b%b for pc %h",
                bundle.inst0Valid, bundle.inst1Valid, pc));
        end
        if (!pc[2] && bundle.inst0 !== (base ^ memKey)) begin
            reportError($sformatf("inst0 %h, expected %h", bundle.inst0, base ^ memKey));
        end
        if (bundle.inst1 !== ((base + 32'd4) ^ memKey)) begin
            reportError($sformatf("inst1 %h, expected %h",
                bundle.inst1, (base + 32'd4) ^ memKey));
        end
    endtask

    initial begin
        errorCount  = 0;
        acceptCount = 0;
        bundleCount = 0;
        reqCount    = 0;
        pendValid   = 1'b0;
        clearModel();
    end

    // everything a cycle does is taken at its middle, where all signals are settled
    always @(negedge clk) begin : watch
        int         set;
        logic [1:0] way;
        if (rst) begin
            pendValid = 1'b0;
            clearModel();
        end else begin
            if (bundleValid) begin
                bundleCount++;
                if (!pendValid) begin
                    reportError("bundle appeared with no fetch outstanding");
                end else begin
                    checkBundle(pendPc);
                    set = int'(pendPc[9:4]);
                    if (!pendHit && !pendRespSeen) begin
                        reportError("miss bundle arrived before the memory response");
                    end
                    // flush in the same cycle wins over age and fill updates
                    if (!flush && pendHit) begin
                        modelAge[set] = ageAfterUse(modelAge[set], pendWay);
                    end else if (!flush) begin
                        way = pickVictim(set);
                        modelTag[set][way]   = pendPc[31:10];
                        modelValid[set][way] = 1'b1;
                        modelAge[set]        = ageAfterUse(modelAge[set], way);
                    end
                    pendValid = 1'b0;
                end
            end else if (pendValid && pendHit) begin
                reportError($sformatf("no bundle one cycle after hit on pc %h", pendPc));
                pendValid = 1'b0;
            end

            if (memReqValid && memReqReady) begin
                reqCount++;
                if (!pendValid || pendHit || pendReqSeen) begin
                    reportError($sformatf("unexpected memory request %h", memReq.lineAddr));
                end else if (memReq.lineAddr !== {pendPc[31:4], 4'b0000}) begin
                    reportError($sformatf("memory request %h, expected %h",
                        memReq.lineAddr, {pendPc[31:4], 4'b0000}));
                end
                pendReqSeen = 1'b1;
            end
            if (memRespValid && memRespReady) begin
                pendRespSeen = 1'b1;
            end

            if (flush) begin
                clearModel();
            end

            if (fetchValid && fetchReady) begin
                acceptCount++;
                set          = int'(fetchPc[9:4]);
                pendValid    = 1'b1;
                pendHit      = 1'b0;
                pendReqSeen  = 1'b0;
                pendRespSeen = 1'b0;
                pendPc       = fetchPc;
                for (int w = 0; w < numWays; w++) begin
                    if (modelValid[set][w] && modelTag[set][w] == fetchPc[31:10]) begin
                        pendHit = 1'b1;
                        pendWay = 2'(w);
                    end
                end
            end
        end
    end

endmodule

// File: sim/icacheProtocol_chk.sv
`timescale 1ns/1ps

module icacheProtocolChk (
    input logic                 clk,
    input logic                 rst,
    input logic                 fetchValid,
    input logic                 fetchReady,
    input logic                 bundleValid,
    input logic                 memReqValid,
    input logic                 memReqReady,
    input icachePkg::memReqT    memReq
);
    int failCount = 0;
    int outstanding;

    // accepted fetches that have not produced a bundle yet
    always_ff @(posedge clk) begin
        if (rst) begin
            outstanding <= 0;
        end else begin
            outstanding <= outstanding + ((fetchValid && fetchReady) ? 1 : 0)
                - (bundleValid ? 1 : 0);
        end
    end

    reqHeld: assert property (@(posedge clk) disable iff (rst)
        memReqValid && !memReqReady |=> memReqValid && $stable(memReq))
    else begin
        failCount++;
        $error("memory request dropped or changed before acceptance");
    end

    bundleHasFetch: assert property (@(posedge clk) disable iff (rst)
        bundleValid |-> outstanding != 0)
    else begin
        failCount++;
        $error("bundle with no accepted fetch behind it");
    end

    readyLowOnMiss: assert property (@(posedge clk) disable iff (rst)
        memReqValid |-> !fetchReady)
    else begin
        failCount++;
        $error("fetchReady high while a memory request is pending");
    end

endmodule

bind icacheTop icacheProtocolChk protocolChk_i (.*);

// File: sim/icacheTb.sv
`timescale 1ns/1ps

module icacheTb;
    localparam int          numReqs    = 2000;
    localparam int          cycleLimit = numReqs * 10;
    localparam int          drainLimit = 50;
    localparam logic [31:0] memKey     = 32'h5A3C_96E1;

    logic                   clk;
    logic                   rst;
    logic                   flush;
    logic                   fetchValid;
    logic                   fetchReady;
    icachePkg::addrT        fetchPc;
    logic                   bundleValid;
    icachePkg::fetchBundleT bundle;
    logic                   memReqValid;
    logic                   memReqReady;
    icachePkg::memReqT      memReq;
    logic                   memRespValid;
    logic                   memRespReady;
    icachePkg::lineT        memRespLine;
    int                     errorCount;
    int                     acceptCount;
    int                     bundleCount;
    int                     reqCount;
    int                     cycleCount;
    logic [31:0]            stimState;
    logic [31:0]            memState;

    tbClock clockGen_i (.clk(clk), .rst(rst));

    icacheTop #(.numSets(64), .numWays(4)) icacheTop_i (.*);

    icacheMonitor #(.numSets(64), .numWays(4), .memKey(memKey)) monitor_i (.*);

    function automatic logic [31:0] xorshift(logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic idleCycles(int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // a few fixed PCs in set 7 first, then a small random pool of 6 tags over 4 sets
    task automatic choosePc(int i, output icachePkg::addrT pc);
        logic [21:0] tag;
        if (i < 10) begin
            tag = 22'(10 + i % 5);
            pc  = {tag, 6'd7, 4'h0};
        end else begin
            stimState = xorshift(stimState);
            tag = 22'(32 + stimState[31:16] % 6);
            pc  = {tag, 4'b0000, stimState[5:4], stimState[3:2], 2'b00};
        end
    endtask

    initial begin : memResponder
        logic            taken;
        icachePkg::addrT lineAddr;
        memReqReady  = 1'b0;
        memRespValid = 1'b0;
        memRespLine  = '0;
        memState     = xorshift(32'd32317);
        @(negedge rst);
        forever begin
            memState = xorshift(memState);
            idleCycles(int'(memState[15:0] % 6));
            memReqReady = 1'b1;
            do begin
                @(negedge clk);
                taken    = memReqValid;
                lineAddr = memReq.lineAddr;
                @(posedge clk);
                #1;
            end while (!taken);
            memReqReady = 1'b0;
            idleCycles(int'(memState[31:16] % 6));
            memRespValid = 1'b1;
            for (int k = 0; k < 4; k++) begin
                memRespLine[32*k +: 32] = (lineAddr + 32'(4 * k)) ^ memKey;
            end
            do begin
                @(negedge clk);
                taken = memRespReady;
                @(posedge clk);
                #1;
            end while (!taken);
            memRespValid = 1'b0;
        end
    end

    initial begin : timeout
        cycleCount = 0;
        while (cycleCount < cycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("timeout: the run did not finish within %0d cycles", cycleLimit);
        $display("Simulation failed");
        $finish;
    end

    initial begin : stimulus
        icachePkg::addrT pc;
        logic            taken;
        int              totalErrors;
        int              drainCycles;
        flush      = 1'b0;
        fetchValid = 1'b0;
        fetchPc    = '0;
        stimState  = 32'd32317;
        @(negedge rst);
        for (int i = 0; i < numReqs; i++) begin
            choosePc(i, pc);
            stimState = xorshift(stimState);
            if (i >= 10 && stimState[9:8] == 2'b00) begin
                idleCycles(int'(stimState[11:10]));
            end
            if (i >= 10 && stimState[20:16] == 5'd0) begin
                flush = 1'b1;
                idleCycles(1);
                flush = 1'b0;
            end
            fetchValid = 1'b1;
            fetchPc    = pc;
            do begin
                @(negedge clk);
                taken = fetchReady;
                @(posedge clk);
                #1;
            end while (!taken);
            fetchValid = 1'b0;
        end
        // the last refill gets a bounded window to deliver its bundle
        drainCycles = 0;
        while (bundleCount != acceptCount && drainCycles < drainLimit) begin
            idleCycles(1);
            drainCycles++;
        end
        idleCycles(5);
        totalErrors = errorCount + icacheTop_i.protocolChk_i.failCount;
        if (bundleCount != acceptCount) begin
            $display("bundle count %0d does not match accepted fetch count %0d",
                bundleCount, acceptCount);
        end
        $display("errors %0d, assertion failures %0d, fetches %0d, bundles %0d, refills %0d",
            errorCount, icacheTop_i.protocolChk_i.failCount, acceptCount, bundleCount,
            reqCount);
        if (totalErrors == 0 && bundleCount == acceptCount) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: list.f
design/icachePkg.sv
design/fetchLookup.sv
design/cacheStore.sv
design/refillEngine.sv
design/icacheTop.sv
sim/tbClock.sv
sim/icacheMonitor.sv
sim/icacheProtocol_chk.sv
sim/icacheTb.sv

// File: run.sh
#!/bin/sh
# build and run the icache testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f list.f --top-module icacheTb -o icacheSim
./obj_dir/icacheSim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
if ! grep -q "Simulation completed successfully" sim.log; then
    exit 1
fi
